/* src/uart_link_config.svh */
// UART frame and FIFO settings
`ifndef UART_LINK_CONFIG_SVH
`define UART_LINK_CONFIG_SVH

// data bits per frame
`define UART_DBIT 8

// oversampling ticks in the stop bit
`define UART_SB_TICK 16

// FIFO address width for a depth of 2**aw
`define UART_FIFO_AW 2

// width of the baud divisor input
`define UART_DVSR_W 11

`endif

/* src/uart_link_pkg.sv */
// UART link types
`default_nettype none

`include "uart_link_config.svh"

package uart_link_pkg;

   // one data byte on the line
   typedef logic [`UART_DBIT-1:0] byte_t;

   // received byte with its stop-bit status
   typedef struct packed
   {
      byte_t data;
      logic  frame_err;
   } rx_frame_t;

endpackage

`default_nettype wire

/* src/baud_tick_gen.sv */
// Oversampling tick divider
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_config.svh"

module baud_tick_gen
   (
      input  wire                     clk,
      input  wire                     rst,
      input  wire [`UART_DVSR_W-1:0]  dvsr,
      output logic                    s_tick
   );

   logic [`UART_DVSR_W-1:0] cnt_reg;
   logic [`UART_DVSR_W-1:0] lim_reg;
   logic                    wrap;

   assign wrap = (cnt_reg == lim_reg);

   // divisor is picked up only on a wrap
   always_ff @(posedge clk, posedge rst)
      if (rst)
      begin
         cnt_reg <= '0;
         lim_reg <= '0;
      end
      else if (wrap)
      begin
         cnt_reg <= '0;
         lim_reg <= dvsr;
      end
      else
         cnt_reg <= cnt_reg + 1'b1;

   assign s_tick = wrap;

endmodule

`default_nettype wire

/* src/uart_rx.sv */
// UART receiver
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_config.svh"

module uart_rx
   (
      input  wire                    clk,
      input  wire                    rst,
      input  wire                    rx,
      input  wire                    s_tick,
      output logic                   rx_done,
      output uart_link_pkg::rx_frame_t frame
   );

   import uart_link_pkg::*;

   localparam int nw = $clog2(`UART_DBIT);

   typedef enum logic [1:0] {idle, start, data, stop} rx_state_t;

   rx_state_t         state_reg, state_next;
   logic [3:0]        s_reg, s_next;
   logic [nw-1:0]     n_reg, n_next;
   byte_t             b_reg, b_next;
   logic              rx_prev;

   always_ff @(posedge clk, posedge rst)
      if (rst)
      begin
         state_reg <= idle;
         s_reg     <= '0;
         n_reg     <= '0;
         rx_prev   <= 1'b1;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         rx_prev   <= rx;
      end

   // data shift register
   always_ff @(posedge clk)
      b_reg <= b_next;

   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      rx_done    = 1'b0;
      case (state_reg)
         idle:
            // a line held low after a bad stop bit is no new start
            if (rx_prev && !rx)
            begin
               state_next = start;
               s_next     = '0;
            end
         start:
            if (s_tick)
               if (s_reg == 4'd7)
               begin
                  state_next = data;
                  s_next     = '0;
                  n_next     = '0;
               end
               else
                  s_next = s_reg + 1'b1;
         data:
            if (s_tick)
               if (s_reg == 4'd15)
               begin
                  s_next = '0;
                  b_next = {rx, b_reg[`UART_DBIT-1:1]};
                  if (n_reg == nw'(`UART_DBIT-1))
                     state_next = stop;
                  else
                     n_next = n_reg + 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
         stop:
            if (s_tick)
               if (s_reg == 4'(`UART_SB_TICK-1))
               begin
                  state_next = idle;
                  rx_done    = 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
         default:
            state_next = idle;
      endcase
   end

   // stop bit sampled on the rx_done cycle
   assign frame.data      = b_reg;
   assign frame.frame_err = ~rx;

endmodule

`default_nettype wire

/* src/uart_tx.sv */
// UART transmitter
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_config.svh"

module uart_tx
   (
      input  wire                  clk,
      input  wire                  rst,
      input  wire                  s_tick,
      input  wire                  tx_ready,
      input  wire uart_link_pkg::byte_t din,
      output logic                 tx_done,
      output logic                 tx
   );

   import uart_link_pkg::*;

   localparam int nw = $clog2(`UART_DBIT);

   typedef enum logic [1:0] {idle, start, data, stop} tx_state_t;

   tx_state_t         state_reg, state_next;
   logic [3:0]        s_reg, s_next;
   logic [nw-1:0]     n_reg, n_next;
   byte_t             b_reg, b_next;
   logic              tx_reg, tx_next;

   always_ff @(posedge clk, posedge rst)
      if (rst)
      begin
         state_reg <= idle;
         s_reg     <= '0;
         n_reg     <= '0;
         tx_reg    <= 1'b1;
      end
      else
      begin
         state_reg <= state_next;
         s_reg     <= s_next;
         n_reg     <= n_next;
         tx_reg    <= tx_next;
      end

   always_ff @(posedge clk)
      b_reg <= b_next;

   // line level changes only on bit boundaries
   always_comb
   begin
      state_next = state_reg;
      s_next     = s_reg;
      n_next     = n_reg;
      b_next     = b_reg;
      tx_next    = tx_reg;
      tx_done    = 1'b0;
      case (state_reg)
         idle:
            if (tx_ready)
            begin
               state_next = start;
               s_next     = '0;
               b_next     = din;
               tx_next    = 1'b0;
            end
         start:
            if (s_tick)
               if (s_reg == 4'd15)
               begin
                  state_next = data;
                  s_next     = '0;
                  n_next     = '0;
                  tx_next    = b_reg[0];
               end
               else
                  s_next = s_reg + 1'b1;
         data:
            if (s_tick)
               if (s_reg == 4'd15)
               begin
                  s_next = '0;
                  b_next = b_reg >> 1;
                  if (n_reg == nw'(`UART_DBIT-1))
                  begin
                     state_next = stop;
                     tx_next    = 1'b1;
                  end
                  else
                  begin
                     n_next  = n_reg + 1'b1;
                     tx_next = b_reg[1];
                  end
               end
               else
                  s_next = s_reg + 1'b1;
         stop:
            if (s_tick)
               if (s_reg == 4'(`UART_SB_TICK-1))
               begin
                  state_next = idle;
                  tx_done    = 1'b1;
               end
               else
                  s_next = s_reg + 1'b1;
         default:
            state_next = idle;
      endcase
   end

   assign tx = tx_reg;

endmodule

`default_nettype wire

/* src/byte_fifo.sv */
// First-word-fallthrough FIFO
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
   #(
      parameter type payload_t = uart_link_pkg::byte_t,
      parameter int  aw        = 2
   )
   (
      input  wire           clk,
      input  wire           rst,
      input  wire           wr,
      input  wire payload_t w_data,
      input  wire           rd,
      output payload_t      r_data,
      output logic          empty,
      output logic          full
   );

   payload_t          mem [2**aw];
   logic [aw-1:0]     w_ptr, r_ptr;
   logic              full_reg, empty_reg;
   logic              wr_ok, rd_ok;

   assign rd_ok = rd && !empty_reg;
   // full still takes a write when a read frees a slot
   assign wr_ok = wr && (!full_reg || rd_ok);

   always_ff @(posedge clk)
      if (wr_ok)
         mem[w_ptr] <= w_data;

   always_ff @(posedge clk, posedge rst)
      if (rst)
      begin
         w_ptr     <= '0;
         r_ptr     <= '0;
         full_reg  <= 1'b0;
         empty_reg <= 1'b1;
      end
      else
         case ({wr_ok, rd_ok})
            2'b01:
            begin
               r_ptr     <= r_ptr + 1'b1;
               full_reg  <= 1'b0;
               empty_reg <= (r_ptr + 1'b1 == w_ptr);
            end
            2'b10:
            begin
               w_ptr     <= w_ptr + 1'b1;
               empty_reg <= 1'b0;
               full_reg  <= (w_ptr + 1'b1 == r_ptr);
            end
            2'b11:
            begin
               w_ptr <= w_ptr + 1'b1;
               r_ptr <= r_ptr + 1'b1;
            end
            default:
            begin
               w_ptr <= w_ptr;
               r_ptr <= r_ptr;
            end
         endcase

   // head word always on the output
   assign r_data = mem[r_ptr];
   assign empty  = empty_reg;
   assign full   = full_reg;

endmodule

`default_nettype wire

/* src/uart_link.sv */
// UART link top level
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_config.svh"

module uart_link
   (
      input  wire                       clk,
      input  wire                       rst,
      input  wire [`UART_DVSR_W-1:0]    dvsr,
      input  wire                       rx,
      output logic                      tx,
      input  wire                       wr_uart,
      input  wire uart_link_pkg::byte_t w_data,
      output logic                      tx_full,
      input  wire                       rd_uart,
      output uart_link_pkg::rx_frame_t  r_data,
      output logic                      rx_empty
   );

   import uart_link_pkg::*;

   logic      s_tick;
   logic      rx_done, tx_done;
   logic      tx_empty, tx_ready;
   rx_frame_t rx_frame;
   byte_t     tx_din;

   baud_tick_gen baud_gen (
      .clk    (clk),
      .rst    (rst),
      .dvsr   (dvsr),
      .s_tick (s_tick)
   );

   // receive path
   uart_rx rx_unit (
      .clk     (clk),
      .rst     (rst),
      .rx      (rx),
      .s_tick  (s_tick),
      .rx_done (rx_done),
      .frame   (rx_frame)
   );

   byte_fifo #(.payload_t(rx_frame_t), .aw(`UART_FIFO_AW)) rx_fifo (
      .clk    (clk),
      .rst    (rst),
      .wr     (rx_done),
      .w_data (rx_frame),
      .rd     (rd_uart),
      .r_data (r_data),
      .empty  (rx_empty),
      .full   ()
   );

   // transmit path
   byte_fifo #(.payload_t(byte_t), .aw(`UART_FIFO_AW)) tx_fifo (
      .clk    (clk),
      .rst    (rst),
      .wr     (wr_uart),
      .w_data (w_data),
      .rd     (tx_done),
      .r_data (tx_din),
      .empty  (tx_empty),
      .full   (tx_full)
   );

   assign tx_ready = ~tx_empty;

   uart_tx tx_unit (
      .clk      (clk),
      .rst      (rst),
      .s_tick   (s_tick),
      .tx_ready (tx_ready),
      .din      (tx_din),
      .tx_done  (tx_done),
      .tx       (tx)
   );

endmodule

`default_nettype wire

/* test/uart_link_tb.sv */
// UART link testbench
`timescale 1ns/1ps
`default_nettype none

`include "uart_link_config.svh"

module uart_link_tb;

   import uart_link_pkg::*;

   localparam logic [1:0] mode_loop = 2'd0;
   localparam logic [1:0] mode_inj = 2'd1;
   localparam logic [1:0] mode_inj_bad = 2'd2;
   localparam int tbl_len = 8;
   localparam int bit_clks = 64;
   localparam int rx_timeout = 2000;

   typedef struct packed
   {
      byte_t      data;
      logic [1:0] mode;
      logic       exp_err;
   } entry_t;

   logic                    clk, rst, rx_bb, loop_en;
   logic [`UART_DVSR_W-1:0] dvsr;
   logic                    wr_uart, rd_uart, tx, tx_full, rx_empty;
   byte_t                   w_data;
   rx_frame_t               r_data;
   wire                     rx_line;
   entry_t                  stim_tbl [tbl_len];
   logic [31:0]             seed;

   // loopback ties the receiver to the transmitter
   assign rx_line = loop_en ? tx : rx_bb;

   uart_link UUT (
      .clk (clk), .rst (rst), .dvsr (dvsr), .rx (rx_line), .tx (tx),
      .wr_uart (wr_uart), .w_data (w_data), .tx_full (tx_full),
      .rd_uart (rd_uart), .r_data (r_data), .rx_empty (rx_empty)
   );

   always #50 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   task automatic report_fail(input string msg);
      $display("%s", msg);
      $display("Done: errors found");
      $fatal(1, "simulation stopped at first error");
   endtask

   // inputs change 10 ns after the rising edge
   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic check_idle(input string when);
      assert (tx === 1'b1 && rx_empty === 1'b1 && tx_full === 1'b0)
      else
         report_fail($sformatf(
            "Mismatch at %0t: idle outputs wrong %s, tx %b rx_empty %b tx_full %b",
            $time, when, tx, rx_empty, tx_full));
   endtask

   task automatic write_byte(input byte_t b);
      next_cycle();
      wr_uart = 1'b1;
      w_data  = b;
      next_cycle();
      wr_uart = 1'b0;
   endtask

   task automatic hold_bit(input logic v);
      int c;
      rx_bb = v;
      for (c = 0; c < bit_clks; c++)
         @(posedge clk);
      #10;
   endtask

   // start, 8 data bits lsb first, stop, then one idle bit
   task automatic send_frame(input byte_t b, input logic stop_low);
      logic [9:0] bits;
      int         k;
      bits = {~stop_low, b, 1'b0};
      for (k = 0; k < 10; k++)
         hold_bit(bits[k]);
      hold_bit(1'b1);
   endtask

   task automatic read_and_check(input byte_t exp_data, input logic exp_err, input string what);
      int n;
      n = 0;
      @(negedge clk);
      while (rx_empty && n < rx_timeout)
      begin
         @(negedge clk);
         n++;
      end
      assert (!rx_empty)
      else
         report_fail($sformatf("Timeout at %0t: no byte received for %s", $time, what));
      assert (r_data.data === exp_data && r_data.frame_err === exp_err)
      else
         report_fail($sformatf("Mismatch at %0t: %s got %02h err %b, expected %02h err %b",
            $time, what, r_data.data, r_data.frame_err, exp_data, exp_err));
      next_cycle();
      rd_uart = 1'b1;
      next_cycle();
      rd_uart = 1'b0;
   endtask

   task automatic fill_table();
      stim_tbl[0] = {8'h55, mode_loop, 1'b0};
      stim_tbl[1] = {8'ha3, mode_loop, 1'b0};
      stim_tbl[2] = {8'h0f, mode_inj, 1'b0};
      stim_tbl[3] = {8'hc6, mode_inj_bad, 1'b1};
      stim_tbl[4] = {8'h01, mode_loop, 1'b0};
      stim_tbl[5] = {8'h80, mode_inj, 1'b0};
      stim_tbl[6] = {8'hff, mode_inj_bad, 1'b1};
      stim_tbl[7] = {8'h3c, mode_inj, 1'b0};
   endtask

   task automatic burst_test();
      byte_t sent [6];
      byte_t accepted [$];
      logic  full_seen;
      int    k;
      full_seen = 1'b0;
      loop_en   = 1'b1;
      for (k = 0; k < 6; k++)
      begin
         seed    = xorshift32(seed);
         sent[k] = seed[7:0];
      end
      for (k = 0; k < 6; k++)
      begin
         next_cycle();
         if (tx_full)
            full_seen = 1'b1;
         else
            accepted.push_back(sent[k]);
         wr_uart = 1'b1;
         w_data  = sent[k];
      end
      next_cycle();
      wr_uart = 1'b0;
      assert (full_seen)
      else
         report_fail("tx_full never went high during six back to back writes");
      // nothing leaves the FIFO during the burst
      assert (accepted.size() == 2**`UART_FIFO_AW)
      else
         report_fail($sformatf("Mismatch at %0t: %0d bytes accepted in burst, expected %0d",
            $time, accepted.size(), 2**`UART_FIFO_AW));
      for (k = 0; k < accepted.size(); k++)
         read_and_check(accepted[k], 1'b0, $sformatf("burst byte %0d", k));
      for (k = 0; k < 2 * 10 * bit_clks; k++)
      begin
         @(negedge clk);
         assert (rx_empty)
         else
            report_fail($sformatf("Mismatch at %0t: byte %02h arrived after the burst",
               $time, r_data.data));
      end
      next_cycle();
   endtask

   task automatic overflow_test();
      byte_t sent [6];
      int    k;
      loop_en = 1'b0;
      for (k = 0; k < 6; k++)
      begin
         seed    = xorshift32(seed);
         sent[k] = seed[7:0];
         send_frame(sent[k], 1'b0);
      end
      for (k = 0; k < 2**`UART_FIFO_AW; k++)
         read_and_check(sent[k], 1'b0, $sformatf("overflow frame %0d", k));
      @(negedge clk);
      assert (rx_empty)
      else
         report_fail($sformatf("Mismatch at %0t: rx FIFO kept a dropped frame %02h",
            $time, r_data.data));
      next_cycle();
   endtask

   initial
   begin
      clk     = 1'b0;
      rst     = 1'b1;
      dvsr    = `UART_DVSR_W'(3);
      wr_uart = 1'b0;
      rd_uart = 1'b0;
      w_data  = '0;
      rx_bb   = 1'b1;
      loop_en = 1'b0;
      seed    = 32'h974c;
      fill_table();
      repeat (10)
      begin
         @(negedge clk);
         check_idle("during reset");
      end
      next_cycle();
      rst = 1'b0;
      @(negedge clk);
      check_idle("after reset");
      next_cycle();
      for (int i = 0; i < tbl_len; i++)
      begin
         if (stim_tbl[i].mode == mode_loop)
         begin
            loop_en = 1'b1;
            write_byte(stim_tbl[i].data);
         end
         else
         begin
            loop_en = 1'b0;
            send_frame(stim_tbl[i].data, stim_tbl[i].mode == mode_inj_bad);
         end
         read_and_check(stim_tbl[i].data, stim_tbl[i].exp_err, $sformatf("table entry %0d", i));
      end
      burst_test();
      overflow_test();
      $display("Done: no errors");
      $finish;
   end

endmodule

`default_nettype wire

/* uart_link.f */
+incdir+src
src/uart_link_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/byte_fifo.sv
src/uart_link.sv
test/uart_link_tb.sv

/* Bender.yml */
package:
  name: uart_link

# uart_link_config.svh is picked up through this include directory
export_include_dirs:
  - src

sources:
  - files:
      - src/uart_link_pkg.sv
      - src/baud_tick_gen.sv
      - src/uart_rx.sv
      - src/uart_tx.sv
      - src/byte_fifo.sv
      - src/uart_link.sv
  - target: test
    files:
      - test/uart_link_tb.sv
